/* booth_mul.f */
logic/booth_mul_pkg.sv
logic/booth_recoder.sv
logic/booth_mul_ctrl.sv
logic/booth_mul_datapath.sv
logic/booth_mul_top.sv
dv/booth_mul_tb.sv

/* dv/booth_mul_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_mul_tb;
	import booth_mul_pkg::*;

	localparam int XLEN        = 64;
	localparam int RST_CYCLES  = 4;
	// record words in order mulw sign mulcand muler flush delay hi lo
	localparam int REC         = 7;
	localparam int MAX_TESTS   = 64;
	// radix-4 steps plus one from acceptance edge to out_valid
	localparam int FULL_LAT    = 34;
	localparam int WORD_LAT    = 18;
	// worst case cycles per test including gap and request
	localparam int TEST_CYCLES = 40;
	// first word of the record after the last test
	localparam logic [63:0] END_MARK = 64'he;

	logic            clk;
	logic            rst;
	logic            mul_valid;
	logic            flush;
	logic            mulw;
	mul_sign_t       mul_signed;
	logic [XLEN-1:0] mulcand;
	logic [XLEN-1:0] muler;
	wire             mul_ready;
	wire             out_valid;
	wire [XLEN-1:0]  result_hi;
	wire [XLEN-1:0]  result_lo;

	logic [63:0] tests_mem [0:MAX_TESTS*REC-1];
	int          n_tests  = 0;
	int          limit    = 0;
	int          cycles   = 0;
	// errors of the running test
	int          err_cnt  = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	logic [31:0] rng;

	booth_mul_top #(
		.XLEN(XLEN)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.mul_valid  (mul_valid),
		.flush      (flush),
		.mulw       (mulw),
		.mul_signed (mul_signed),
		.mulcand    (mulcand),
		.muler      (muler),
		.mul_ready  (mul_ready),
		.out_valid  (out_valid),
		.result_hi  (result_hi),
		.result_lo  (result_lo)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit armed once the test count is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run still going after %0d cycles", limit);
			$display("Verification failed");
			$finish;
		end
	end

	// ******************************
	// helpers
	// ******************************

	// idle gap source
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_value(input int num, input string name,
		input logic [63:0] got, input logic [63:0] exp);
		$display("error: test %0d %s got 0x%016h expected 0x%016h", num, name, got, exp);
		err_cnt++;
	endtask

	task automatic report_fail(input int num, input string msg);
		$display("test %0d: %s", num, msg);
		err_cnt++;
	endtask

	task automatic close_test(input int num, input string desc);
		if (err_cnt == 0) begin
			pass_cnt++;
			$display("test %0d %s: ok", num, desc);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", num, desc, err_cnt);
		end
	endtask

	// ******************************
	// one record from the file
	// ******************************

	task automatic run_test(input int num);
		int          base;
		logic        w;
		logic [1:0]  sg;
		logic [63:0] a;
		logic [63:0] b;
		int          fl_dly;
		logic [63:0] exp_hi;
		logic [63:0] exp_lo;
		int          exp_lat;
		int          lat;
		logic        ready_bad;
		base      = (num - 1) * REC;
		w         = tests_mem[base][0];
		sg        = tests_mem[base+1][1:0];
		a         = tests_mem[base+2];
		b         = tests_mem[base+3];
		fl_dly    = int'(tests_mem[base+4]);
		exp_hi    = tests_mem[base+5];
		exp_lo    = tests_mem[base+6];
		exp_lat   = w ? WORD_LAT : FULL_LAT;
		err_cnt   = 0;
		ready_bad = 1'b0;
		rng       = xorshift32(rng);
		repeat (rng[1:0]) @(posedge clk);
		@(posedge clk);
		mul_valid  <= 1'b1;
		mulw       <= w;
		mul_signed <= sg;
		mulcand    <= a;
		muler      <= b;
		@(negedge clk);
		if (!mul_ready) report_fail(num, "mul_ready low when the request was presented");
		// scramble inputs after the acceptance edge
		// the DUT works on its latched copies
		@(posedge clk);
		mul_valid  <= 1'b0;
		mulw       <= ~w;
		mul_signed <= ~sg;
		mulcand    <= ~a;
		muler      <= ~b;
		lat = 0;
		// flush is high across edge number fl_dly after acceptance
		while (lat < fl_dly) begin
			if (lat == fl_dly - 1) flush <= 1'b1;
			@(negedge clk);
			if (mul_ready) ready_bad = 1'b1;
			@(posedge clk);
			lat++;
		end
		if (fl_dly > 0) begin
			flush <= 1'b0;
			@(negedge clk);
			if (!mul_ready) report_fail(num, "mul_ready still low the cycle after flush");
			if (out_valid) report_fail(num, "out_valid high right after flush");
			// no result for the abandoned operation over the full latency
			while (lat < FULL_LAT) begin
				@(posedge clk);
				lat++;
				@(negedge clk);
				if (out_valid) report_fail(num, "out_valid pulsed for a flushed operation");
			end
		end else begin
			@(negedge clk);
			while (!out_valid && lat < FULL_LAT + 4) begin
				if (mul_ready) ready_bad = 1'b1;
				@(posedge clk);
				lat++;
				@(negedge clk);
			end
			if (!out_valid) begin
				report_fail(num, "no out_valid within the expected latency");
			end else begin
				if (lat != exp_lat) begin
					report_value(num, "out_valid latency", 64'(lat), 64'(exp_lat));
				end
				if (!mul_ready) report_fail(num, "mul_ready low in the out_valid cycle");
			end
		end
		if (ready_bad) report_fail(num, "mul_ready high while the operation was busy");
		// flushed records carry the previous results
		if (result_hi !== exp_hi) report_value(num, "result_hi", result_hi, exp_hi);
		if (result_lo !== exp_lo) report_value(num, "result_lo", result_lo, exp_lo);
		close_test(num, fl_dly > 0 ? "flush" : (w ? "mulw" : "mul"));
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int i;
		rst        = 1'b1;
		mul_valid  = 1'b0;
		flush      = 1'b0;
		mulw       = 1'b0;
		mul_signed = '0;
		mulcand    = '0;
		muler      = '0;
		rng        = 32'd23;
		$readmemh("dv/booth_mul_tests.txt", tests_mem);
		// records run until the end marker
		while (n_tests < MAX_TESTS &&
			(tests_mem[n_tests*REC] === 64'h0 || tests_mem[n_tests*REC] === 64'h1)) begin
			n_tests++;
		end
		if (n_tests == 0 || (n_tests < MAX_TESTS && tests_mem[n_tests*REC] !== END_MARK)) begin
			$display("test file missing, empty or malformed after %0d records", n_tests);
			fail_cnt++;
		end
		limit = n_tests * TEST_CYCLES + RST_CYCLES;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		err_cnt = 0;
		if (!mul_ready) report_fail(0, "mul_ready low after reset");
		if (out_valid) report_fail(0, "out_valid high after reset");
		if (result_hi !== 64'h0) report_value(0, "result_hi", result_hi, 64'h0);
		if (result_lo !== 64'h0) report_value(0, "result_lo", result_lo, 64'h0);
		close_test(0, "reset");
		for (i = 1; i <= n_tests; i++) begin
			run_test(i);
		end
		$display("summary: %0d tests, %0d passed, %0d failed",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/booth_mul_tests.txt */
// mulw sign mulcand muler flush_dly exp_hi exp_lo, all hex, one test per line
// sign bit 1 multiplicand signed, bit 0 multiplier signed; flush_dly 0 means no flush
// unsigned full width
0 0 0000000000000000 0000000000000000 00 0000000000000000 0000000000000000
0 0 0000000000000003 0000000000000005 00 0000000000000000 000000000000000f
0 0 ffffffffffffffff ffffffffffffffff 00 fffffffffffffffe 0000000000000001
0 0 8000000000000000 0000000000000002 00 0000000000000001 0000000000000000
0 0 ffffffffffffffff 0000000000000002 00 0000000000000001 fffffffffffffffe
0 0 123456789abcdef0 0000000000000010 00 0000000000000001 23456789abcdef00
0 0 00000000deadbeef 0000000100000000 00 0000000000000000 deadbeef00000000
0 0 8000000000000000 8000000000000000 00 4000000000000000 0000000000000000
// signed modes full width
0 1 0000000000000004 fffffffffffffffa 00 ffffffffffffffff ffffffffffffffe8
0 3 ffffffffffffffff ffffffffffffffff 00 0000000000000000 0000000000000001
0 3 8000000000000000 8000000000000000 00 4000000000000000 0000000000000000
0 3 8000000000000000 7fffffffffffffff 00 c000000000000000 8000000000000000
0 3 0000000000000007 fffffffffffffffd 00 ffffffffffffffff ffffffffffffffeb
0 2 ffffffffffffffff ffffffffffffffff 00 ffffffffffffffff 0000000000000001
0 1 ffffffffffffffff ffffffffffffffff 00 ffffffffffffffff 0000000000000001
0 2 fffffffffffffffe 0000000000000003 00 ffffffffffffffff fffffffffffffffa
0 1 8000000000000000 ffffffffffffffff 00 ffffffffffffffff 8000000000000000
0 3 123456789abcdef0 ffffffffffffffff 00 ffffffffffffffff edcba98765432110
0 2 7fffffffffffffff 8000000000000000 00 3fffffffffffffff 8000000000000000
// word mode, upper operand bits are garbage
1 0 deadbeef00000003 cafebabe00000005 00 0000000000000000 000000000000000f
1 3 12345678ffffffff 87654321ffffffff 00 0000000000000000 0000000000000001
1 0 a5a5a5a5ffffffff 5a5a5a5affffffff 00 00000000fffffffe 0000000000000001
1 3 ffffffff80000000 0000000180000000 00 0000000040000000 0000000000000000
1 1 ffffffff00000004 00000000fffffffa 00 ffffffffffffffff ffffffffffffffe8
1 2 1111111180000000 22222222ffffffff 00 ffffffff80000000 ffffffff80000000
1 0 0000000080000000 0000000000000002 00 0000000000000001 0000000000000000
1 0 fedcba9840000000 0123456700000002 00 0000000000000000 ffffffff80000000
// flush, expected values are the results of the record before
0 3 123456789abcdef0 ffffffffffffffff 05 0000000000000000 ffffffff80000000
0 0 0000000000000003 0000000000000005 00 0000000000000000 000000000000000f
1 3 00000000ffffffff 00000000ffffffff 03 0000000000000000 000000000000000f
1 3 00000000fffffffe 0000000000000003 00 ffffffffffffffff fffffffffffffffa
0 0 ffffffffffffffff ffffffffffffffff 01 ffffffffffffffff fffffffffffffffa
0 3 0000000000000004 fffffffffffffffa 00 ffffffffffffffff ffffffffffffffe8
// end marker
e 0 0 0 0 0 0

/* logic/booth_mul_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_mul_ctrl #(
	parameter int XLEN = 64
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  mul_valid,
	input  wire  flush,
	input  wire  mulw,
	output logic mul_ready,
	output logic load,
	output logic step,
	output logic finish,
	output logic word
);
	import booth_mul_pkg::*;

	localparam int CNT_W = step_cnt_bits(XLEN);

	// step counts for full and half width, operand plus two guard bits
	localparam logic [CNT_W-1:0] STEPS_FULL = CNT_W'(mul_steps(XLEN + 2));
	localparam logic [CNT_W-1:0] STEPS_WORD = CNT_W'(mul_steps(XLEN / 2 + 2));

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_FINISH
	} state_t;

	state_t           state;
	state_t           state_nx;
	// steps still to run
	logic [CNT_W-1:0] cnt;

	// ******************************
	// strobes
	// ******************************

	assign mul_ready = (state == ST_IDLE);
	// acceptance edge
	assign load      = mul_valid & mul_ready & ~flush;
	// flush kills the strobes in the same cycle
	assign step      = (state == ST_BUSY) & ~flush;
	assign finish    = (state == ST_FINISH) & ~flush;

	// ******************************
	// fsm
	// ******************************

	always_comb begin
		state_nx = state;
		case (state)
			ST_IDLE: begin
				if (load) begin
					state_nx = ST_BUSY;
				end
			end
			// last step runs on this edge
			ST_BUSY: begin
				if (cnt == CNT_W'(1)) begin
					state_nx = ST_FINISH;
				end
			end
			ST_FINISH: state_nx = ST_IDLE;
			default: state_nx = ST_IDLE;
		endcase
		// abort from anywhere
		if (flush) begin
			state_nx = ST_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cnt   <= '0;
			word  <= 1'b0;
		end else begin
			state <= state_nx;
			if (load) begin
				cnt  <= mulw ? STEPS_WORD : STEPS_FULL;
				word <= mulw;
			end else if (step) begin
				cnt <= cnt - CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/booth_mul_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_mul_datapath #(
	parameter int XLEN = 64
) (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           load,
	input  wire                           step,
	input  wire                           finish,
	input  wire                           word,
	input  wire booth_mul_pkg::mul_sign_t mul_signed,
	input  wire                           mulw,
	input  wire [XLEN-1:0]                mulcand,
	input  wire [XLEN-1:0]                muler,
	output logic [XLEN-1:0]               result_hi,
	output logic [XLEN-1:0]               result_lo,
	output logic                          out_valid
);
	import booth_mul_pkg::*;

	// ******************************
	// widths
	// ******************************

	// word mode operand width
	localparam int HALF = XLEN / 2;
	// extended operand, two guard bits above the msb
	localparam int EW = XLEN + 2;
	// product width, all adds wrap modulo 2**PW
	localparam int PW = 2 * XLEN;
	// shift amount, reaches 2*steps after the last step
	localparam int SHW = $clog2(2 * mul_steps(EW) + 1);

	// sign or zero extension of the full or the low half operand
	function automatic logic [EW-1:0] ext_operand(
		input logic [XLEN-1:0] val,
		input logic            is_signed,
		input logic            half
	);
		logic fill;
		fill = is_signed & (half ? val[HALF-1] : val[XLEN-1]);
		if (half) begin
			return {{(EW-HALF){fill}}, val[HALF-1:0]};
		end
		return {{(EW-XLEN){fill}}, val};
	endfunction

	// held multiplicand
	logic [EW-1:0]  mcand_ext;
	// multiplier with the implied zero below bit 0
	logic [EW:0]    mplier_sr;
	// running sum of weighted partial products
	logic [PW-1:0]  acc;
	// bit weight of the current step
	logic [SHW-1:0] weight;

	// recoder outputs
	booth_op_t      op;
	logic [EW-1:0]  pp;
	logic           neg;

	// last digit applied, kept for waveform debug
	booth_op_t      last_op;

	// partial product with carry, moved to its weight
	logic [PW-1:0]  addend;

	// formatted results
	logic [XLEN-1:0] hi_fmt;
	logic [XLEN-1:0] lo_fmt;

	// ******************************
	// booth recoder
	// ******************************

	booth_recoder #(
		.WIDTH(EW)
	) recoder_i (
		.window    (mplier_sr[2:0]),
		.mcand_ext (mcand_ext),
		.op        (op),
		.pp        (pp),
		.neg       (neg)
	);

	// sign extend the partial product, fold in the carry, then shift
	// ~x + 1 at weight 2k equals -(x << 2k) modulo 2**PW
	assign addend = ({{(PW-EW){pp[EW-1]}}, pp} + PW'(neg)) << weight;

	// ******************************
	// operand load and steps
	// ******************************

	always_ff @(posedge clk) begin
		if (load) begin
			mcand_ext <= ext_operand(mulcand, mul_signed[MCAND_SIGN_BIT], mulw);
			mplier_sr <= {ext_operand(muler, mul_signed[MPLIER_SIGN_BIT], mulw), 1'b0};
			acc       <= '0;
			weight    <= '0;
			last_op   <= BOOTH_ZERO;
		end else if (step) begin
			acc       <= acc + addend;
			// next window, sign bits fill in from the top
			mplier_sr <= {{2{mplier_sr[EW]}}, mplier_sr[EW:2]};
			weight    <= weight + SHW'(2);
			last_op   <= op;
		end
	end

	// ******************************
	// result formatting
	// ******************************

	// word mode
	// lo: low half of the product, sign extended from its top bit
	// hi: upper half of the word product, carried with its own extension
	always_comb begin
		if (word) begin
			lo_fmt = {{(XLEN-HALF){acc[HALF-1]}}, acc[HALF-1:0]};
			hi_fmt = acc[XLEN+HALF-1:HALF];
		end else begin
			lo_fmt = acc[XLEN-1:0];
			hi_fmt = acc[PW-1:XLEN];
		end
	end

	// results hold until the next finish
	always_ff @(posedge clk) begin
		if (rst) begin
			result_hi <= '0;
			result_lo <= '0;
			out_valid <= 1'b0;
		end else begin
			// single cycle strobe
			out_valid <= finish;
			if (finish) begin
				result_hi <= hi_fmt;
				result_lo <= lo_fmt;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/booth_mul_pkg.sv */
`default_nettype none

package booth_mul_pkg;

	// ******************************
	// operand signedness
	// ******************************

	// bit 1 multiplicand signed, bit 0 multiplier signed
	typedef logic [1:0] mul_sign_t;

	// bit positions inside mul_sign_t
	localparam int MCAND_SIGN_BIT  = 1;
	localparam int MPLIER_SIGN_BIT = 0;

	// ******************************
	// radix-4 booth digit
	// ******************************

	// top bit is the sign, low two bits the magnitude
	typedef enum logic [2:0] {
		BOOTH_ZERO = 3'b000,
		BOOTH_POS1 = 3'b001,
		BOOTH_POS2 = 3'b010,
		BOOTH_NEG1 = 3'b101,
		BOOTH_NEG2 = 3'b110
	} booth_op_t;

	// radix-4 steps to cover an extended operand, two bits per step
	function automatic int mul_steps(input int ext_width);
		return (ext_width + 1) / 2;
	endfunction

	// counter width able to hold the full-width step count
	function automatic int step_cnt_bits(input int xlen);
		return $clog2(mul_steps(xlen + 2) + 1);
	endfunction

endpackage

`default_nettype wire

/* logic/booth_mul_top.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_mul_top #(
	parameter int XLEN = 64
) (
	input  wire                           clk,
	input  wire                           rst,
	// operation request
	input  wire                           mul_valid,
	input  wire                           flush,
	input  wire                           mulw,
	input  wire booth_mul_pkg::mul_sign_t mul_signed,
	input  wire [XLEN-1:0]                mulcand,
	input  wire [XLEN-1:0]                muler,
	// status and result
	output wire                           mul_ready,
	output wire                           out_valid,
	output wire [XLEN-1:0]                result_hi,
	output wire [XLEN-1:0]                result_lo
);

	// ******************************
	// controller to datapath
	// ******************************

	// acceptance strobe
	wire load;
	// one per busy cycle
	wire step;
	// cycle after the last step
	wire finish;
	// mulw as latched at acceptance
	wire word;

	// ******************************
	// step controller
	// ******************************

	booth_mul_ctrl #(
		.XLEN(XLEN)
	) ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mulw      (mulw),
		.mul_ready (mul_ready),
		.load      (load),
		.step      (step),
		.finish    (finish),
		.word      (word)
	);

	// ******************************
	// datapath with booth recoder
	// ******************************

	booth_mul_datapath #(
		.XLEN(XLEN)
	) datapath_i (
		.clk        (clk),
		.rst        (rst),
		.load       (load),
		.step       (step),
		.finish     (finish),
		.word       (word),
		.mul_signed (mul_signed),
		.mulw       (mulw),
		.mulcand    (mulcand),
		.muler      (muler),
		.result_hi  (result_hi),
		.result_lo  (result_lo),
		.out_valid  (out_valid)
	);

endmodule

`default_nettype wire

/* logic/booth_recoder.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_recoder #(
	parameter int WIDTH = 66
) (
	input  wire [2:0]                window,
	input  wire [WIDTH-1:0]          mcand_ext,
	output booth_mul_pkg::booth_op_t op,
	output logic [WIDTH-1:0]         pp,
	output logic                     neg
);
	import booth_mul_pkg::*;

	// magnitude selection before the optional inversion
	logic [WIDTH-1:0] sel;

	// ******************************
	// digit decode
	// ******************************

	// window is {b(2k+1), b(2k), b(2k-1)}
	always_comb begin
		case (window)
			3'b001,
			3'b010: op = BOOTH_POS1;
			3'b011: op = BOOTH_POS2;
			3'b100: op = BOOTH_NEG2;
			3'b101,
			3'b110: op = BOOTH_NEG1;
			// 000 and 111 both mean no add
			default: op = BOOTH_ZERO;
		endcase
	end

	// ******************************
	// partial product
	// ******************************

	always_comb begin
		case (op)
			BOOTH_POS1,
			BOOTH_NEG1: sel = mcand_ext;
			// x2, the extra top bit of mcand_ext absorbs the shift
			BOOTH_POS2,
			BOOTH_NEG2: sel = {mcand_ext[WIDTH-2:0], 1'b0};
			default: sel = '0;
		endcase
	end

	// negative digits: one's complement here, +1 comes in as neg
	always_comb begin
		neg = op[2];
		if (neg) begin
			pp = ~sel;
		end else begin
			pp = sel;
		end
	end

endmodule

`default_nettype wire
